// File: src.f
+incdir+.
rv_core_pkg.sv
rv_decode.sv
rv_reg_file.sv
rv_stage_reg.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f src.f \
    --top-module tb_rv_core \
    -o tb_rv_core

./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    import rv_core_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTR    = 90;  // Issued over all tests
    localparam int TIMEOUT_NS   = (NUM_INSTR * 4 + RESET_CYCLES) * CLK_PERIOD * 2;

    // RV32I major opcodes in bits 6:0
    localparam logic [6:0] OP_R     = 7'h33;
    localparam logic [6:0] OP_I     = 7'h13;
    localparam logic [6:0] OP_LUI   = 7'h37;
    localparam logic [6:0] OP_AUIPC = 7'h17;
    localparam logic [6:0] OP_BR    = 7'h63;
    localparam logic [6:0] OP_JAL   = 7'h6f;
    localparam logic [6:0] OP_JALR  = 7'h67;
    localparam logic [6:0] OP_LOAD  = 7'h03;
    localparam logic [6:0] OP_STORE = 7'h23;

    logic     clk;
    logic     rst_i;
    logic     instr_valid_i;
    fetch_s   instr_i;
    res_s     res_o;
    rv_word_t model [32];  // Register file as the ISA sees it
    rv_word_t pc;
    int       errors;
    int       n_issued;

    rv_core_top UUT (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .res_o         (res_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic rv_word_t r_type(logic [6:0] f7, rv_reg_addr_t rs2, rv_reg_addr_t rs1,
                                        logic [2:0] f3, rv_reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic rv_word_t i_type(logic [11:0] imm, rv_reg_addr_t rs1, logic [2:0] f3,
                                        rv_reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_word_t s_type(logic [11:0] imm, rv_reg_addr_t rs2, rv_reg_addr_t rs1,
                                        logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic rv_word_t b_type(logic [12:0] imm, rv_reg_addr_t rs2, rv_reg_addr_t rs1,
                                        logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR};
    endfunction

    function automatic rv_word_t u_type(logic [19:0] imm, rv_reg_addr_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_word_t j_type(logic [20:0] imm, rv_reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic rv_word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Expected ALU result per funct3 with alt selecting SUB and SRA
    function automatic rv_word_t alu_ref(logic [2:0] f3, logic alt, rv_word_t a, rv_word_t b);
        rv_word_t   r;
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: r = {31'b0, $signed(a) < $signed(b)};
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) r = $signed(a) >>> sh;
                else     r = a >> sh;
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic br_ref(logic [2:0] f3, rv_word_t a, rv_word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_word(string name, rv_word_t exp, rv_word_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(string name, rv_reg_addr_t exp, rv_reg_addr_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // Issues one instruction at pc and checks its retire record
    task automatic run_instr(string name, rv_word_t instr, logic exp_wr, rv_word_t exp_data,
                             logic exp_redirect, rv_word_t exp_target, logic exp_illegal);
        @(negedge clk);
        check_flag({name, " idle valid"}, 1'b0, res_o.valid);  // Previous result gone
        instr_valid_i  = 1'b1;
        instr_i.pc     = pc;
        instr_i.instr  = instr;
        n_issued++;
        @(negedge clk);  // Taken on the rising edge in between
        instr_valid_i = 1'b0;
        @(negedge clk);  // Retired after the following rising edge
        if (!res_o.valid) begin
            $display("Test %s: no result on res_o in the cycle after issue", name);
            errors++;
        end else begin
            check_flag({name, " rd_wr_en"}, exp_wr, res_o.rd_wr_en);
            if (exp_wr) begin
                check_addr({name, " rd_addr"}, instr[11:7], res_o.rd_addr);
                check_word({name, " rd_data"}, exp_data, res_o.rd_data);
            end
            check_flag({name, " redirect"}, exp_redirect, res_o.redirect);
            if (exp_redirect) check_word({name, " target"}, exp_target, res_o.target_pc);
            check_flag({name, " illegal"}, exp_illegal, res_o.illegal);
        end
        if (exp_wr && instr[11:7] != 5'd0) model[instr[11:7]] = exp_data;
        pc = pc + 32'd4;
    endtask

    // LUI then ADDI with the upper part rounded for the signed low part
    task automatic load_reg(string name, rv_reg_addr_t rd, rv_word_t value);
        rv_word_t hi;
        hi = value + 32'h800;
        run_instr({name, " lui"}, u_type(hi[31:12], rd, OP_LUI), 1'b1, {hi[31:12], 12'b0},
                  1'b0, 32'd0, 1'b0);
        run_instr({name, " addi"}, i_type(value[11:0], rd, 3'b000, rd, OP_I), 1'b1,
                  alu_ref(3'b000, 1'b0, model[rd], sext12(value[11:0])), 1'b0, 32'd0, 1'b0);
    endtask

    task automatic after_reset_checks();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_flag("reset idle valid", 1'b0, res_o.valid);
        end
        run_instr("ADD x1,x0,x0", r_type(7'b0, 5'd0, 5'd0, 3'b000, 5'd1), 1'b1, 32'd0,
                  1'b0, 32'd0, 1'b0);
        run_instr("ADDI x0", i_type(12'h123, 5'd0, 3'b000, 5'd0, OP_I), 1'b1, 32'h123,
                  1'b0, 32'd0, 1'b0);
        run_instr("ADD x3,x0,x0", r_type(7'b0, 5'd0, 5'd0, 3'b000, 5'd3), 1'b1, 32'd0,
                  1'b0, 32'd0, 1'b0);
        // Registers not yet written read as cleared by reset
        run_instr("ADD x14,x12,x13", r_type(7'b0, 5'd13, 5'd12, 3'b000, 5'd14), 1'b1,
                  alu_ref(3'b000, 1'b0, model[12], model[13]), 1'b0, 32'd0, 1'b0);
    endtask

    task automatic reg_reg_alu();
        rv_word_t   a;
        rv_word_t   b;
        logic [2:0] f3;
        for (int round = 0; round < 2; round++) begin
            a = $urandom();
            b = $urandom();
            if (round == 0) a = a | 32'h8000_0000;  // Negative rs1 so SRA sign fills
            load_reg("rr x5", 5'd5, a);
            load_reg("rr x6", 5'd6, b);
            for (int i = 0; i < 8; i++) begin
                f3 = 3'(i);
                run_instr($sformatf("rr f3=%0d", i), r_type(7'b0, 5'd6, 5'd5, f3, 5'd7), 1'b1,
                          alu_ref(f3, 1'b0, model[5], model[6]), 1'b0, 32'd0, 1'b0);
            end
            run_instr("rr SUB", r_type(7'b0100000, 5'd6, 5'd5, 3'b000, 5'd7), 1'b1,
                      alu_ref(3'b000, 1'b1, model[5], model[6]), 1'b0, 32'd0, 1'b0);
            run_instr("rr SRA", r_type(7'b0100000, 5'd6, 5'd5, 3'b101, 5'd7), 1'b1,
                      alu_ref(3'b101, 1'b1, model[5], model[6]), 1'b0, 32'd0, 1'b0);
        end
    endtask

    task automatic imm_and_upper();
        rv_word_t    r;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [2:0]  f3;
        r = $urandom();
        load_reg("imm x5", 5'd5, r | 32'h8000_0000);
        for (int i = 0; i < 8; i++) begin
            f3  = 3'(i);
            r   = $urandom();
            imm = r[11:0];
            sh  = r[16:12];
            if (f3 == 3'b001) begin
                run_instr("SLLI", i_type({7'b0, sh}, 5'd5, f3, 5'd8, OP_I), 1'b1,
                          alu_ref(f3, 1'b0, model[5], {27'b0, sh}), 1'b0, 32'd0, 1'b0);
            end else if (f3 == 3'b101) begin
                run_instr("SRLI", i_type({7'b0, sh}, 5'd5, f3, 5'd8, OP_I), 1'b1,
                          alu_ref(f3, 1'b0, model[5], {27'b0, sh}), 1'b0, 32'd0, 1'b0);
                run_instr("SRAI", i_type({7'b0100000, sh}, 5'd5, f3, 5'd8, OP_I), 1'b1,
                          alu_ref(f3, 1'b1, model[5], {27'b0, sh}), 1'b0, 32'd0, 1'b0);
            end else begin
                run_instr($sformatf("imm f3=%0d", i), i_type(imm, 5'd5, f3, 5'd8, OP_I), 1'b1,
                          alu_ref(f3, 1'b0, model[5], sext12(imm)), 1'b0, 32'd0, 1'b0);
            end
        end
        run_instr("LUI", u_type(r[31:12], 5'd8, OP_LUI), 1'b1, {r[31:12], 12'b0},
                  1'b0, 32'd0, 1'b0);
        run_instr("AUIPC", u_type(r[31:12], 5'd9, OP_AUIPC), 1'b1, pc + {r[31:12], 12'b0},
                  1'b0, 32'd0, 1'b0);
    endtask

    task automatic cond_branches();
        rv_word_t    a_val [3];
        rv_word_t    b_val [3];
        rv_word_t    r;
        logic [12:0] bimm;
        logic [2:0]  f3;
        a_val[0] = $urandom();
        b_val[0] = a_val[0];       // Equal
        a_val[1] = 32'h8000_0010;  // Negative signed but large unsigned
        b_val[1] = 32'd5;
        a_val[2] = 32'd5;
        b_val[2] = 32'h8000_0010;
        for (int p = 0; p < 3; p++) begin
            load_reg("br x10", 5'd10, a_val[p]);
            load_reg("br x11", 5'd11, b_val[p]);
            for (int i = 0; i < 8; i++) begin
                f3 = 3'(i);
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    r    = $urandom();
                    bimm = {r[11:0], 1'b0};
                    run_instr($sformatf("branch f3=%0d pair %0d", i, p),
                              b_type(bimm, 5'd11, 5'd10, f3), 1'b0, 32'd0,
                              br_ref(f3, model[10], model[11]),
                              pc + {{19{bimm[12]}}, bimm}, 1'b0);
                end
            end
        end
    endtask

    task automatic jumps();
        rv_word_t    r;
        logic [20:0] jimm;
        logic [11:0] imm;
        r    = $urandom();
        jimm = {r[20:1], 1'b0};
        run_instr("JAL", j_type(jimm, 5'd1), 1'b1, pc + 32'd4, 1'b1,
                  pc + {{11{jimm[20]}}, jimm}, 1'b0);
        load_reg("jalr x5", 5'd5, $urandom());
        imm = r[31:20] | 12'h001;  // Odd offset so target bit 0 stays set
        run_instr("JALR odd", i_type(imm, 5'd5, 3'b000, 5'd2, OP_JALR), 1'b1, pc + 32'd4,
                  1'b1, model[5] + sext12(imm), 1'b0);
        imm = r[31:20] & 12'hffe;
        run_instr("JALR even", i_type(imm, 5'd5, 3'b000, 5'd3, OP_JALR), 1'b1, pc + 32'd4,
                  1'b1, model[5] + sext12(imm), 1'b0);
    endtask

    task automatic illegal_instrs();
        rv_word_t r;
        r = $urandom();
        load_reg("ill x4", 5'd4, r | 32'h0000_0001);  // Nonzero so a stray write shows up
        run_instr("LW", i_type(12'h010, 5'd5, 3'b010, 5'd4, OP_LOAD), 1'b0, 32'd0,
                  1'b0, 32'd0, 1'b1);
        run_instr("SW", s_type(12'h020, 5'd6, 5'd5, 3'b010), 1'b0, 32'd0, 1'b0, 32'd0, 1'b1);
        run_instr("ECALL", 32'h0000_0073, 1'b0, 32'd0, 1'b0, 32'd0, 1'b1);
        run_instr("FENCE", 32'h0ff0_000f, 1'b0, 32'd0, 1'b0, 32'd0, 1'b1);
        run_instr("custom-0", i_type(12'h000, 5'd5, 3'b000, 5'd4, 7'h0b), 1'b0, 32'd0,
                  1'b0, 32'd0, 1'b1);
        run_instr("MUL", r_type(7'b0000001, 5'd6, 5'd5, 3'b000, 5'd4), 1'b0, 32'd0,
                  1'b0, 32'd0, 1'b1);
        run_instr("f7 alt xor", r_type(7'b0100000, 5'd6, 5'd5, 3'b100, 5'd4), 1'b0, 32'd0,
                  1'b0, 32'd0, 1'b1);
        // x4 must still hold what the model has
        run_instr("x4 readback", r_type(7'b0, 5'd0, 5'd4, 3'b000, 5'd7), 1'b1, model[4],
                  1'b0, 32'd0, 1'b0);
    endtask

    initial begin
        errors        = 0;
        n_issued      = 0;
        clk           = 1'b0;
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc            = 32'h0000_1000;
        for (int i = 0; i < 32; i++) model[i] = 32'd0;
        void'($urandom(32'h5f1c));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        after_reset_checks();
        reg_reg_alu();
        imm_and_upper();
        cond_branches();
        jumps();
        illegal_instrs();

        @(negedge clk);
        $display("Instructions issued: %0d, errors: %0d", n_issued, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Instructions issued: %0d, errors: %0d", n_issued, errors);
        $display("sim failed");
        $finish;
    end

endmodule : tb_rv_core

`default_nettype wire

// File: rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 instr_valid_i,
    input  rv_core_pkg::fetch_s instr_i,
    output rv_core_pkg::res_s   res_o
);

    import rv_core_pkg::*;

    rv_reg_addr_t rs1_addr;
    rv_reg_addr_t rs2_addr;
    rv_word_t     rs1_data;
    rv_word_t     rs2_data;
    id2exe_s      id2exe_d;
    id2exe_s      id2exe_q;
    logic         exe_valid;
    exe2res_s     exe2res_d;
    exe2res_s     exe2res_q;
    logic         res_valid;
    rf_wr_s       rf_wr;

    rv_decode u_decode (
        .fetch_i    (instr_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id2exe_o   (id2exe_d)
    );

    rv_reg_file u_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (rf_wr)  // Writeback from result stage
    );

    rv_stage_reg #(
        .payload_t (id2exe_s)
    ) u_id_exe (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (instr_valid_i),
        .data_i  (id2exe_d),
        .valid_o (exe_valid),
        .data_o  (id2exe_q)
    );

    rv_execute u_execute (
        .id2exe_i  (id2exe_q),
        .exe2res_o (exe2res_d)
    );

    rv_stage_reg #(
        .payload_t (exe2res_s)
    ) u_exe_res (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (exe_valid),
        .data_i  (exe2res_d),
        .valid_o (res_valid),
        .data_o  (exe2res_q)
    );

    rv_result u_result (
        .valid_i   (res_valid),
        .exe2res_i (exe2res_q),
        .rf_wr_o   (rf_wr),
        .res_o     (res_o)
    );

endmodule : rv_core_top

`default_nettype wire

// File: rv_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_result (
    input  wire                   valid_i,
    input  rv_core_pkg::exe2res_s exe2res_i,
    output rv_core_pkg::rf_wr_s   rf_wr_o,
    output rv_core_pkg::res_s     res_o
);

    import rv_core_pkg::*;

    rv_word_t wb_data;
    logic     wr_en;
    logic     redirect;

    always_comb begin
        case (exe2res_i.rd_wb_sel)
            RD_WB_INC_PC: wb_data = exe2res_i.pc + `RV_XLEN'(`RV_PC_STEP);  // Link address
            RD_WB_ALU:    wb_data = exe2res_i.alu_result;
            default:      wb_data = '0;
        endcase
    end

    assign wr_en    = valid_i && exe2res_i.rd_wr_req && !exe2res_i.illegal;
    assign redirect = valid_i && (exe2res_i.branch_taken || exe2res_i.jump)
                      && !exe2res_i.illegal;

    // Feedback to the register file
    assign rf_wr_o.en   = wr_en;
    assign rf_wr_o.addr = exe2res_i.rd_addr;
    assign rf_wr_o.data = wb_data;

    always_comb begin
        res_o.valid     = valid_i;
        res_o.rd_wr_en  = wr_en;
        res_o.rd_addr   = exe2res_i.rd_addr;
        res_o.rd_data   = wb_data;
        res_o.redirect  = redirect;
        res_o.target_pc = exe2res_i.alu_result;  // Taken branch or jump target
        res_o.illegal   = valid_i && exe2res_i.illegal;
    end

endmodule : rv_result

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_execute (
    input  rv_core_pkg::id2exe_s  id2exe_i,
    output rv_core_pkg::exe2res_s exe2res_o
);

    import rv_core_pkg::*;

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    rv_word_t           opr1;
    rv_word_t           opr2;
    rv_word_t           alu_result;
    logic [SHAMT_W-1:0] shamt;
    logic               cmp_eq;
    logic               cmp_lt;
    logic               cmp_ltu;
    logic               branch_taken;

    // Operand selection
    assign opr1  = (id2exe_i.opr1_sel == OPR1_PC)  ? id2exe_i.pc  : id2exe_i.rs1_data;
    assign opr2  = (id2exe_i.opr2_sel == OPR2_IMM) ? id2exe_i.imm : id2exe_i.rs2_data;
    assign shamt = opr2[SHAMT_W-1:0];  // Low 5 bits only

    always_comb begin
        case (id2exe_i.alu_op)
            ALU_OPS_ADD:       alu_result = opr1 + opr2;
            ALU_OPS_SUB:       alu_result = opr1 - opr2;
            ALU_OPS_SLL:       alu_result = opr1 << shamt;
            ALU_OPS_SLT:       alu_result = `RV_XLEN'($signed(opr1) < $signed(opr2));
            ALU_OPS_SLTU:      alu_result = `RV_XLEN'(opr1 < opr2);
            ALU_OPS_XOR:       alu_result = opr1 ^ opr2;
            ALU_OPS_SRL:       alu_result = opr1 >> shamt;
            ALU_OPS_SRA:       alu_result = rv_word_t'($signed(opr1) >>> shamt);
            ALU_OPS_OR:        alu_result = opr1 | opr2;
            ALU_OPS_AND:       alu_result = opr1 & opr2;
            ALU_OPS_COPY_OPR2: alu_result = opr2;
            default:           alu_result = '0;
        endcase
    end

    // Branch compare always uses the two register operands
    assign cmp_eq  = (id2exe_i.rs1_data == id2exe_i.rs2_data);
    assign cmp_lt  = ($signed(id2exe_i.rs1_data) < $signed(id2exe_i.rs2_data));
    assign cmp_ltu = (id2exe_i.rs1_data < id2exe_i.rs2_data);

    always_comb begin
        case (id2exe_i.branch_op)
            BR_EQ:   branch_taken = cmp_eq;
            BR_NE:   branch_taken = !cmp_eq;
            BR_LT:   branch_taken = cmp_lt;
            BR_GE:   branch_taken = !cmp_lt;
            BR_LTU:  branch_taken = cmp_ltu;
            BR_GEU:  branch_taken = !cmp_ltu;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        exe2res_o.alu_result   = alu_result;
        exe2res_o.pc           = id2exe_i.pc;
        exe2res_o.branch_taken = branch_taken;
        exe2res_o.jump         = id2exe_i.jump_req;
        exe2res_o.rd_wb_sel    = id2exe_i.rd_wb_sel;
        exe2res_o.rd_wr_req    = id2exe_i.rd_wr_req;
        exe2res_o.rd_addr      = id2exe_i.rd_addr;
        exe2res_o.illegal      = id2exe_i.illegal;
    end

endmodule : rv_execute

`default_nettype wire

// File: rv_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire      clk,
    input  wire      rst_i,
    input  wire      valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    import rv_core_pkg::*;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Payload is only meaningful while valid_o is high
    always_ff @(posedge clk) begin
        data_o <= data_i;
    end

endmodule : rv_stage_reg

`default_nettype wire

// File: rv_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_reg_file (
    input  wire                       clk,
    input  wire                       rst_i,
    input  rv_core_pkg::rv_reg_addr_t rs1_addr_i,
    input  rv_core_pkg::rv_reg_addr_t rs2_addr_i,
    output rv_core_pkg::rv_word_t     rs1_data_o,
    output rv_core_pkg::rv_word_t     rs2_data_o,
    input  rv_core_pkg::rf_wr_s       wr_i
);

    rv_core_pkg::rv_word_t regs [`RV_RF_DEPTH];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.en && (wr_i.addr != '0)) begin  // x0 stays zero
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Asynchronous read ports
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule : rv_reg_file

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_decode (
    input  rv_core_pkg::fetch_s       fetch_i,
    output rv_core_pkg::rv_reg_addr_t rs1_addr_o,
    output rv_core_pkg::rv_reg_addr_t rs2_addr_o,
    input  rv_core_pkg::rv_word_t     rs1_data_i,
    input  rv_core_pkg::rv_word_t     rs2_data_i,
    output rv_core_pkg::id2exe_s      id2exe_o
);

    import rv_core_pkg::*;

    rv_word_t     instr;
    rv_opcode_e   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic [4:0]   shamt;
    rv_word_t     imm_i;
    rv_word_t     imm_u;
    rv_word_t     imm_b;
    rv_word_t     imm_j;
    rv_word_t     imm_shamt;
    logic         illegal;
    id2exe_s      id2exe;

    assign instr  = fetch_i.instr;
    assign opcode = rv_opcode_e'(instr[6:2]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign shamt  = instr[24:20];

    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    // Immediate formats
    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_u     = {instr[31:12], 12'b0};
    assign imm_b     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_shamt = `RV_XLEN'(shamt);  // Zero extended

    always_comb begin
        id2exe.alu_op    = ALU_OPS_NONE;
        id2exe.opr1_sel  = OPR1_REG;
        id2exe.opr2_sel  = OPR2_REG;
        id2exe.branch_op = BR_NONE;
        id2exe.rd_wb_sel = RD_WB_NONE;
        id2exe.rd_wr_req = 1'b0;
        id2exe.jump_req  = 1'b0;
        id2exe.illegal   = 1'b0;
        id2exe.pc        = fetch_i.pc;
        id2exe.imm       = imm_i;
        id2exe.rs1_data  = rs1_data_i;
        id2exe.rs2_data  = rs2_data_i;
        id2exe.rd_addr   = instr[11:7];
        illegal          = (instr[1:0] != 2'b11);  // Compressed encodings are not supported

        case (opcode)
            OPCODE_ARITH: begin
                id2exe.rd_wb_sel = RD_WB_ALU;
                id2exe.rd_wr_req = 1'b1;
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000: id2exe.alu_op = ALU_OPS_ADD;
                            3'b001: id2exe.alu_op = ALU_OPS_SLL;
                            3'b010: id2exe.alu_op = ALU_OPS_SLT;
                            3'b011: id2exe.alu_op = ALU_OPS_SLTU;
                            3'b100: id2exe.alu_op = ALU_OPS_XOR;
                            3'b101: id2exe.alu_op = ALU_OPS_SRL;
                            3'b110: id2exe.alu_op = ALU_OPS_OR;
                            default: id2exe.alu_op = ALU_OPS_AND;
                        endcase
                    end
                    7'b0100000: begin
                        case (funct3)
                            3'b000: id2exe.alu_op = ALU_OPS_SUB;
                            3'b101: id2exe.alu_op = ALU_OPS_SRA;
                            default: illegal = 1'b1;
                        endcase
                    end
                    default: illegal = 1'b1;  // M extension included
                endcase
            end

            OPCODE_IMM: begin
                id2exe.opr2_sel  = OPR2_IMM;
                id2exe.rd_wb_sel = RD_WB_ALU;
                id2exe.rd_wr_req = 1'b1;
                case (funct3)
                    3'b000: id2exe.alu_op = ALU_OPS_ADD;
                    3'b010: id2exe.alu_op = ALU_OPS_SLT;
                    3'b011: id2exe.alu_op = ALU_OPS_SLTU;
                    3'b100: id2exe.alu_op = ALU_OPS_XOR;
                    3'b110: id2exe.alu_op = ALU_OPS_OR;
                    3'b111: id2exe.alu_op = ALU_OPS_AND;
                    3'b001: begin
                        id2exe.imm    = imm_shamt;
                        id2exe.alu_op = ALU_OPS_SLL;
                        illegal       = (funct7 != 7'b0000000);
                    end
                    default: begin
                        // funct3 101, right shifts
                        id2exe.imm = imm_shamt;
                        case (funct7)
                            7'b0000000: id2exe.alu_op = ALU_OPS_SRL;
                            7'b0100000: id2exe.alu_op = ALU_OPS_SRA;
                            default: illegal = 1'b1;
                        endcase
                    end
                endcase
            end

            OPCODE_AUIPC: begin
                id2exe.alu_op    = ALU_OPS_ADD;
                id2exe.opr1_sel  = OPR1_PC;
                id2exe.opr2_sel  = OPR2_IMM;
                id2exe.rd_wb_sel = RD_WB_ALU;
                id2exe.rd_wr_req = 1'b1;
                id2exe.imm       = imm_u;
            end

            OPCODE_LUI: begin
                id2exe.alu_op    = ALU_OPS_COPY_OPR2;
                id2exe.opr2_sel  = OPR2_IMM;
                id2exe.rd_wb_sel = RD_WB_ALU;
                id2exe.rd_wr_req = 1'b1;
                id2exe.imm       = imm_u;
            end

            OPCODE_BRANCH: begin
                id2exe.alu_op   = ALU_OPS_ADD;  // Target is pc + B imm
                id2exe.opr1_sel = OPR1_PC;
                id2exe.opr2_sel = OPR2_IMM;
                id2exe.imm      = imm_b;
                case (funct3)
                    3'b000: id2exe.branch_op = BR_EQ;
                    3'b001: id2exe.branch_op = BR_NE;
                    3'b100: id2exe.branch_op = BR_LT;
                    3'b101: id2exe.branch_op = BR_GE;
                    3'b110: id2exe.branch_op = BR_LTU;
                    3'b111: id2exe.branch_op = BR_GEU;
                    default: illegal = 1'b1;
                endcase
            end

            OPCODE_JALR: begin
                id2exe.alu_op    = ALU_OPS_ADD;  // Target is rs1 + I imm, bit 0 kept
                id2exe.opr2_sel  = OPR2_IMM;
                id2exe.rd_wb_sel = RD_WB_INC_PC;
                id2exe.rd_wr_req = 1'b1;
                id2exe.jump_req  = 1'b1;
                illegal          = illegal | (funct3 != 3'b000);
            end

            OPCODE_JAL: begin
                id2exe.alu_op    = ALU_OPS_ADD;
                id2exe.opr1_sel  = OPR1_PC;
                id2exe.opr2_sel  = OPR2_IMM;
                id2exe.rd_wb_sel = RD_WB_INC_PC;
                id2exe.rd_wr_req = 1'b1;
                id2exe.jump_req  = 1'b1;
                id2exe.imm       = imm_j;
            end

            default: illegal = 1'b1;  // Loads, stores, FENCE, SYSTEM and unknown
        endcase

        // An illegal instruction must not change any state
        if (illegal) begin
            id2exe.alu_op    = ALU_OPS_NONE;
            id2exe.branch_op = BR_NONE;
            id2exe.rd_wb_sel = RD_WB_NONE;
            id2exe.rd_wr_req = 1'b0;
            id2exe.jump_req  = 1'b0;
        end
        id2exe.illegal = illegal;
    end

    assign id2exe_o = id2exe;

endmodule : rv_decode

`default_nettype wire

// File: rv_core_pkg.sv
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]      rv_word_t;
    typedef logic [`RV_RF_AWIDTH-1:0] rv_reg_addr_t;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OPCODE_ARITH  = 5'b01100,
        OPCODE_IMM    = 5'b00100,
        OPCODE_AUIPC  = 5'b00101,
        OPCODE_LUI    = 5'b01101,
        OPCODE_BRANCH = 5'b11000,
        OPCODE_JALR   = 5'b11001,
        OPCODE_JAL    = 5'b11011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_OPS_NONE,
        ALU_OPS_ADD,
        ALU_OPS_SUB,
        ALU_OPS_SLL,
        ALU_OPS_SLT,
        ALU_OPS_SLTU,
        ALU_OPS_XOR,
        ALU_OPS_SRL,
        ALU_OPS_SRA,
        ALU_OPS_OR,
        ALU_OPS_AND,
        ALU_OPS_COPY_OPR2  // Passes operand 2 through, used by LUI
    } alu_op_e;

    typedef enum logic {
        OPR1_REG,
        OPR1_PC
    } opr1_sel_e;

    typedef enum logic {
        OPR2_REG,
        OPR2_IMM
    } opr2_sel_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_op_e;

    typedef enum logic [1:0] {
        RD_WB_NONE,
        RD_WB_ALU,
        RD_WB_INC_PC  // Link address for jumps
    } rd_wb_sel_e;

    typedef struct packed {
        rv_word_t pc;
        rv_word_t instr;
    } fetch_s;

    typedef struct packed {
        alu_op_e      alu_op;
        opr1_sel_e    opr1_sel;
        opr2_sel_e    opr2_sel;
        branch_op_e   branch_op;
        rd_wb_sel_e   rd_wb_sel;
        logic         rd_wr_req;
        logic         jump_req;
        logic         illegal;
        rv_word_t     pc;
        rv_word_t     imm;
        rv_word_t     rs1_data;
        rv_word_t     rs2_data;
        rv_reg_addr_t rd_addr;
    } id2exe_s;

    typedef struct packed {
        rv_word_t     alu_result;  // Also the redirect target
        rv_word_t     pc;
        logic         branch_taken;
        logic         jump;
        rd_wb_sel_e   rd_wb_sel;
        logic         rd_wr_req;
        rv_reg_addr_t rd_addr;
        logic         illegal;
    } exe2res_s;

    typedef struct packed {
        logic         en;
        rv_reg_addr_t addr;
        rv_word_t     data;
    } rf_wr_s;

    typedef struct packed {
        logic         valid;
        logic         rd_wr_en;
        rv_reg_addr_t rd_addr;
        rv_word_t     rd_data;
        logic         redirect;
        rv_word_t     target_pc;
        logic         illegal;
    } res_s;

endpackage : rv_core_pkg

`default_nettype wire

// File: rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data path and PC width
`define RV_XLEN 32

// Register file geometry
`define RV_RF_AWIDTH 5
`define RV_RF_DEPTH 32

// Byte distance to the next sequential instruction
`define RV_PC_STEP 4

`endif
